// ==== ecc_mem_top.f ====
rtl/ecc_pkg.sv
rtl/mem_pkg.sv
rtl/ecc_encode_stage.sv
rtl/ecc_store.sv
rtl/ecc_correct_stage.sv
rtl/ecc_mem_top.sv
verif/ecc_mem_tb.sv

// ==== rtl/ecc_correct_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module ecc_correct_stage (
    input  logic                clk,
    input  logic                rst,
    input  logic                raw_valid,
    input  ecc_pkg::ecc_word_u  raw_word,
    input  logic                raw_bypass,
    output mem_pkg::rd_result_t rd_result
);

    import ecc_pkg::*;

    logic [PARITY_WIDTH-1:0] syndrome;
    logic [DATA_WIDTH-1:0]   flip;
    logic [1:0]              err_class;
    logic [DATA_WIDTH-1:0]   data_fix;
    logic                    sbit;
    logic                    dbit;

    // ==============================
    // Syndrome and decode.
    // ==============================
    always_comb begin
        syndrome = ecc_encode(raw_word.code.data) ^ raw_word.code.parity;
        flip     = ecc_decode(syndrome, err_class);
    end

    // Flip mask is zero on a double error, so raw data passes.
    always_comb begin
        if (raw_bypass) begin
            data_fix = raw_word.code.data;
            sbit     = 1'b0;
            dbit     = 1'b0;
        end else begin
            data_fix = raw_word.code.data ^ flip;
            sbit     = (err_class == ERR_SINGLE);
            dbit     = (err_class == ERR_DOUBLE);
        end
    end

    // ==============================
    // Result register.
    // ==============================
    always_ff @(posedge clk) begin
        rd_result.data     <= data_fix;
        rd_result.sbit_err <= sbit;
        rd_result.dbit_err <= dbit;
        if (rst) begin
            rd_result.valid <= 1'b0;
        end else begin
            rd_result.valid <= raw_valid;
        end
    end

    a_flags_exclusive: assert property (
        @(posedge clk) disable iff (rst)
        rd_result.valid |-> !(rd_result.sbit_err && rd_result.dbit_err)
    );

    // Bypass request one cycle back shows up as a clean result.
    a_bypass_no_flags: assert property (
        @(posedge clk) disable iff (rst)
        (raw_valid && raw_bypass) |=> (!rd_result.sbit_err && !rd_result.dbit_err)
    );

endmodule

`default_nettype wire

// ==== rtl/ecc_encode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module ecc_encode_stage #(
    parameter int  DEPTH = 16,
    localparam int AW    = $clog2(DEPTH)
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           wr_en,
    input  logic [AW-1:0]                  wr_addr,
    input  mem_pkg::wr_req_t               wr_req,
    output logic                           enc_en,
    output logic [AW-1:0]                  enc_addr,
    output ecc_pkg::ecc_word_u             enc_word,
    output logic [ecc_pkg::CODE_WIDTH-1:0] enc_inj
);

    import ecc_pkg::*;

    always_ff @(posedge clk) begin
        if (wr_en) begin // Payload held between writes.
            enc_addr             <= wr_addr;
            enc_inj              <= wr_req.inj;
            enc_word.code.data   <= wr_req.data;
            enc_word.code.parity <= ecc_encode(wr_req.data);
        end
        if (rst) begin
            enc_en <= 1'b0;
        end else begin
            enc_en <= wr_en;
        end
    end

    a_enc_en_known: assert property (
        @(posedge clk) disable iff (rst) !$isunknown(enc_en)
    );

endmodule

`default_nettype wire

// ==== rtl/ecc_mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ecc_mem_top #(
    parameter int  DEPTH = 16,
    localparam int AW    = $clog2(DEPTH)
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                wr_en,
    input  logic [AW-1:0]       wr_addr,
    input  mem_pkg::wr_req_t    wr_req,
    input  logic                rd_en,
    input  logic [AW-1:0]       rd_addr,
    input  logic                rd_bypass,
    output mem_pkg::rd_result_t rd_result
);

    import ecc_pkg::*;

    // ==============================
    // Stage links.
    // ==============================
    logic                  enc_en;
    logic [AW-1:0]         enc_addr;
    ecc_word_u             enc_word;
    logic [CODE_WIDTH-1:0] enc_inj;
    logic                  raw_valid;
    ecc_word_u             raw_word;
    logic                  raw_bypass;

    ecc_encode_stage #(.DEPTH(DEPTH)) u_encode (
        .clk      (clk),
        .rst      (rst),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_req   (wr_req),
        .enc_en   (enc_en),
        .enc_addr (enc_addr),
        .enc_word (enc_word),
        .enc_inj  (enc_inj)
    );

    ecc_store #(.DEPTH(DEPTH)) u_store (
        .clk        (clk),
        .rst        (rst),
        .enc_en     (enc_en),
        .enc_addr   (enc_addr),
        .enc_word   (enc_word),
        .enc_inj    (enc_inj),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_bypass  (rd_bypass),
        .raw_valid  (raw_valid),
        .raw_word   (raw_word),
        .raw_bypass (raw_bypass)
    );

    ecc_correct_stage u_correct (
        .clk        (clk),
        .rst        (rst),
        .raw_valid  (raw_valid),
        .raw_word   (raw_word),
        .raw_bypass (raw_bypass),
        .rd_result  (rd_result)
    );

endmodule

`default_nettype wire

// ==== rtl/ecc_pkg.sv ====
`default_nettype none

package ecc_pkg;

    // ==============================
    // Code geometry.
    // ==============================
    localparam int DATA_WIDTH   = 25;
    localparam int PARITY_WIDTH = 6;
    localparam int CODE_WIDTH   = DATA_WIDTH + PARITY_WIDTH;

    // Error classes, bit 0 single and bit 1 double.
    localparam logic [1:0] ERR_NONE   = 2'b00;
    localparam logic [1:0] ERR_SINGLE = 2'b01;
    localparam logic [1:0] ERR_DOUBLE = 2'b10;

    // Stored codeword, as fields or as one flat vector.
    typedef union packed {
        struct packed {
            logic [PARITY_WIDTH-1:0] parity;
            logic [DATA_WIDTH-1:0]   data;
        } code;
        logic [CODE_WIDTH-1:0] raw;
    } ecc_word_u;

    // ==============================
    // Check bit generation.
    // ==============================
    function automatic logic [PARITY_WIDTH-1:0] ecc_encode(input logic [DATA_WIDTH-1:0] d);
        logic [PARITY_WIDTH-1:0] p;
        p[0] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6] ^ d[8] ^ d[10] ^
               d[11] ^ d[13] ^ d[15] ^ d[17] ^ d[19] ^ d[21] ^ d[23];
        p[1] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6] ^ d[9] ^ d[10] ^
               d[12] ^ d[13] ^ d[16] ^ d[17] ^ d[20] ^ d[21] ^ d[24];
        p[2] = d[1] ^ d[2] ^ d[3] ^ d[7] ^ d[8] ^ d[9] ^ d[10] ^
               d[14] ^ d[15] ^ d[16] ^ d[17] ^ d[22] ^ d[23] ^ d[24];
        p[3] = d[4] ^ d[5] ^ d[6] ^ d[7] ^ d[8] ^ d[9] ^ d[10] ^
               d[18] ^ d[19] ^ d[20] ^ d[21] ^ d[22] ^ d[23] ^ d[24];
        p[4] = ^d[24:11];
        // Extra check bit, makes every data column odd weight.
        p[5] = d[0] ^ d[1] ^ d[2] ^ d[4] ^ d[5] ^ d[7] ^ d[10] ^ d[11] ^
               d[12] ^ d[14] ^ d[17] ^ d[18] ^ d[21] ^ d[23] ^ d[24];
        return p;
    endfunction

    // Returns the data flip mask; class goes out through err_class.
    function automatic logic [DATA_WIDTH-1:0] ecc_decode(
        input  logic [PARITY_WIDTH-1:0] syndrome,
        output logic [1:0]              err_class
    );
        logic [DATA_WIDTH-1:0] flip;
        flip = '0;
        if (syndrome == '0) begin
            err_class = ERR_NONE;
        end else if ($onehot(syndrome)) begin
            err_class = ERR_SINGLE; // Check bit hit.
        end else begin
            err_class = ERR_DOUBLE;
            for (int i = 0; i < DATA_WIDTH; i++) begin
                if (syndrome == ecc_encode(DATA_WIDTH'(1) << i)) begin
                    flip[i]   = 1'b1;
                    err_class = ERR_SINGLE;
                end
            end
        end
        return flip;
    endfunction

endpackage

`default_nettype wire

// ==== rtl/ecc_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module ecc_store #(
    parameter int  DEPTH = 16,
    localparam int AW    = $clog2(DEPTH)
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           enc_en,
    input  logic [AW-1:0]                  enc_addr,
    input  ecc_pkg::ecc_word_u             enc_word,
    input  logic [ecc_pkg::CODE_WIDTH-1:0] enc_inj,
    input  logic                           rd_en,
    input  logic [AW-1:0]                  rd_addr,
    input  logic                           rd_bypass,
    output logic                           raw_valid,
    output ecc_pkg::ecc_word_u             raw_word,
    output logic                           raw_bypass
);

    import ecc_pkg::*;

    logic [CODE_WIDTH-1:0] mem [DEPTH];

    // ==============================
    // Write with fault injection.
    // ==============================
    always_ff @(posedge clk) begin
        if (enc_en) begin
            mem[enc_addr] <= enc_word.raw ^ enc_inj;
        end
    end

    // ==============================
    // Registered read.
    // ==============================
    always_ff @(posedge clk) begin
        if (rd_en) begin
            raw_word.raw <= mem[rd_addr]; // Old word on a same-edge write.
            raw_bypass   <= rd_bypass;
        end
        if (rst) begin
            raw_valid <= 1'b0;
        end else begin
            raw_valid <= rd_en;
        end
    end

    a_wr_addr_range: assert property (
        @(posedge clk) disable iff (rst) enc_en |-> (enc_addr < DEPTH)
    );

    a_rd_addr_range: assert property (
        @(posedge clk) disable iff (rst) rd_en |-> (rd_addr < DEPTH)
    );

endmodule

`default_nettype wire

// ==== rtl/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    // ==============================
    // Write side.
    // ==============================
    typedef struct packed {
        logic [ecc_pkg::DATA_WIDTH-1:0] data;
        logic [ecc_pkg::CODE_WIDTH-1:0] inj;  // Flip mask on the stored codeword.
    } wr_req_t;

    // ==============================
    // Read side.
    // ==============================
    typedef struct packed {
        logic                           valid;
        logic [ecc_pkg::DATA_WIDTH-1:0] data;
        logic                           sbit_err; // Corrected.
        logic                           dbit_err; // Detected, not corrected.
    } rd_result_t;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the ECC memory testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
    --top-module ecc_mem_tb \
    -f ecc_mem_top.f

# The log decides the result.
./obj_dir/Vecc_mem_tb | tee sim.log

if grep -qx "Simulation PASSED" sim.log; then
    echo "Run passed."
    exit 0
fi

echo "Run failed, see sim.log."
exit 1

// ==== verif/ecc_mem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ecc_mem_tb;

    import ecc_pkg::*;
    import mem_pkg::*;

    localparam int DEPTH   = 16;
    localparam int AW      = $clog2(DEPTH);
    localparam int N_PAIRS = 20;
    localparam int N_BYP   = 4;
    localparam int N_RAND  = 200;
    // Writes plus reads over all tests.
    localparam int N_OPS = 2*DEPTH + 2*DATA_WIDTH + 2*PARITY_WIDTH + 2*N_PAIRS + 2*N_BYP + N_RAND;
    localparam int MAX_CYCLES = 4*N_OPS + 100;

    // Code column of each data bit, bit 24 first.
    localparam logic [DATA_WIDTH*PARITY_WIDTH-1:0] CODE_COLS = {
        6'h3E, 6'h3D, 6'h1C, 6'h3B, 6'h1A, 6'h19, 6'h38, 6'h37, 6'h16,
        6'h15, 6'h34, 6'h13, 6'h32, 6'h31, 6'h2F, 6'h0E, 6'h0D, 6'h2C,
        6'h0B, 6'h2A, 6'h29, 6'h07, 6'h26, 6'h25, 6'h23
    };

    logic          clk;
    logic          rst;
    logic          wr_en;
    logic [AW-1:0] wr_addr;
    wr_req_t       wr_req;
    logic          rd_en;
    logic [AW-1:0] rd_addr;
    logic          rd_bypass;
    rd_result_t    rd_result;

    logic [DATA_WIDTH-1:0] sh_data [DEPTH]; // Shadow of written data.
    logic [CODE_WIDTH-1:0] sh_inj [DEPTH];
    int                    last_wr [DEPTH];
    rd_result_t            exp_q [$];
    int                    exp_cyc_q [$];   // Cycle each result is due.
    integer                seed = 32'h4051_541e;
    int                    drive_cyc = 0;
    int                    cycle_cnt = 0;

    ecc_mem_top #(.DEPTH(DEPTH)) UUT (
        .clk       (clk),
        .rst       (rst),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_req    (wr_req),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_bypass (rd_bypass),
        .rd_result (rd_result)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ==============================
    // Reference model.
    // ==============================
    function automatic logic [PARITY_WIDTH-1:0] check_bits(input logic [DATA_WIDTH-1:0] d);
        logic [PARITY_WIDTH-1:0] p;
        p = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            if (d[i]) begin
                p = p ^ CODE_COLS[i*PARITY_WIDTH +: PARITY_WIDTH];
            end
        end
        return p;
    endfunction

    function automatic rd_result_t ref_read(
        input logic [DATA_WIDTH-1:0] data,
        input logic [CODE_WIDTH-1:0] inj,
        input logic                  bypass
    );
        logic [CODE_WIDTH-1:0]   word;
        logic [PARITY_WIDTH-1:0] syn;
        rd_result_t              r;
        word = {check_bits(data), data} ^ inj;
        syn = check_bits(word[DATA_WIDTH-1:0]) ^ word[CODE_WIDTH-1:DATA_WIDTH];
        r.valid = 1'b1;
        r.data = word[DATA_WIDTH-1:0];
        r.sbit_err = 1'b0;
        r.dbit_err = 1'b0;
        if (!bypass && syn != '0) begin
            if ($countones(syn) == 1) begin
                r.sbit_err = 1'b1; // Check bit only.
            end else begin
                r.dbit_err = 1'b1;
                for (int i = 0; i < DATA_WIDTH; i++) begin
                    if (syn == CODE_COLS[i*PARITY_WIDTH +: PARITY_WIDTH]) begin
                        r.data[i] = ~r.data[i];
                        r.sbit_err = 1'b1;
                        r.dbit_err = 1'b0;
                    end
                end
            end
        end
        return r;
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % n);
    endfunction

    function automatic logic [DATA_WIDTH-1:0] rand_data();
        logic [31:0] r;
        r = $random(seed);
        return r[DATA_WIDTH-1:0];
    endfunction

    // Weight 0, 1 or 2, distinct bits.
    function automatic logic [CODE_WIDTH-1:0] rand_mask(input int weight);
        int                    b1;
        int                    b2;
        logic [CODE_WIDTH-1:0] m;
        b1 = rand_below(CODE_WIDTH);
        b2 = (b1 + 1 + rand_below(CODE_WIDTH - 1)) % CODE_WIDTH;
        m = '0;
        if (weight >= 1) begin
            m[b1] = 1'b1;
        end
        if (weight == 2) begin
            m[b2] = 1'b1;
        end
        return m;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "Stopping at first error.");
        end
    endtask

    // ==============================
    // Drivers.
    // ==============================
    task automatic issue_idle();
        @(posedge clk);
        wr_en <= 1'b0;
        rd_en <= 1'b0;
        drive_cyc++;
    endtask

    task automatic issue_write(
        input int                    addr,
        input logic [DATA_WIDTH-1:0] data,
        input logic [CODE_WIDTH-1:0] inj
    );
        @(posedge clk);
        wr_en       <= 1'b1;
        wr_addr     <= addr[AW-1:0];
        wr_req.data <= data;
        wr_req.inj  <= inj;
        rd_en       <= 1'b0;
        sh_data[addr] = data;
        sh_inj[addr]  = inj;
        last_wr[addr] = drive_cyc;
        drive_cyc++;
    endtask

    task automatic issue_read(input int addr, input logic bypass);
        while (drive_cyc - last_wr[addr] < 2) begin
            issue_idle(); // Let a recent write land first.
        end
        @(posedge clk);
        wr_en     <= 1'b0;
        rd_en     <= 1'b1;
        rd_addr   <= addr[AW-1:0];
        rd_bypass <= bypass;
        exp_q.push_back(ref_read(sh_data[addr], sh_inj[addr], bypass));
        // Sampled next edge, valid two edges later, seen by the compare one after.
        exp_cyc_q.push_back(cycle_cnt + 3);
        drive_cyc++;
    endtask

    task automatic write_read(
        input int                    addr,
        input logic [DATA_WIDTH-1:0] data,
        input logic [CODE_WIDTH-1:0] inj,
        input logic                  bypass
    );
        issue_write(addr, data, inj);
        issue_read(addr, bypass);
    endtask

    // ==============================
    // Compare and timeout.
    // ==============================
    always @(posedge clk) begin : compare_results
        rd_result_t exp_res;
        int         exp_cyc;
        if (!rst && rd_result.valid) begin
            if (exp_q.size() == 0) begin
                $display("A read result arrived with no read outstanding.");
                $display("Simulation FAILED");
                $fatal(1, "Unexpected read result.");
            end else begin
                exp_res = exp_q.pop_front();
                exp_cyc = exp_cyc_q.pop_front();
                check_val("rd_result.valid cycle", 32'(cycle_cnt), 32'(exp_cyc));
                check_val("rd_result.data", 32'(rd_result.data), 32'(exp_res.data));
                check_val("rd_result.sbit_err", 32'(rd_result.sbit_err), 32'(exp_res.sbit_err));
                check_val("rd_result.dbit_err", 32'(rd_result.dbit_err), 32'(exp_res.dbit_err));
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles with results still pending.", cycle_cnt);
            $display("Simulation FAILED");
            $fatal(1, "Cycle limit reached.");
        end
    end

    initial begin
        rst       = 1'b1;
        wr_en     = 1'b0;
        wr_addr   = '0;
        wr_req    = '0;
        rd_en     = 1'b0;
        rd_addr   = '0;
        rd_bypass = 1'b0;
        for (int a = 0; a < DEPTH; a++) begin
            last_wr[a] = -10;
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // Clean words, then back-to-back reads.
        for (int a = 0; a < DEPTH; a++) begin
            issue_write(a, rand_data(), '0);
        end
        for (int a = 0; a < DEPTH; a++) begin
            issue_read(a, 1'b0);
        end
        for (int b = 0; b < DATA_WIDTH; b++) begin
            write_read(b % DEPTH, rand_data(), CODE_WIDTH'(1) << b, 1'b0);
        end
        for (int b = 0; b < PARITY_WIDTH; b++) begin
            write_read(b, rand_data(), CODE_WIDTH'(1) << (DATA_WIDTH + b), 1'b0);
        end
        for (int i = 0; i < N_PAIRS; i++) begin
            write_read(rand_below(DEPTH), rand_data(), rand_mask(2), 1'b0);
        end
        for (int i = 0; i < N_BYP; i++) begin
            write_read(i, rand_data(), rand_mask(1 + i % 2), 1'b1);
        end

        // Random mix.
        for (int i = 0; i < N_RAND; i++) begin
            if (rand_below(2) == 0) begin
                issue_write(rand_below(DEPTH), rand_data(), rand_mask(rand_below(3)));
            end else begin
                issue_read(rand_below(DEPTH), rand_below(8) == 0);
            end
        end
        issue_idle();

        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire
